//--- logic/cachePkg.sv
`include "cache_defs.svh"

package cachePkg;

	//////////////////////////////////////////////////////////////////////
	// vector types
	//////////////////////////////////////////////////////////////////////

	typedef logic [`ADDR_W-1:0] addrT;
	typedef logic [`DATA_W-1:0] wordT;
	typedef logic [`TAG_W-1:0] tagT;
	typedef logic [`INDEX_W-1:0] indexT;
	typedef logic [`WORDSEL_W-1:0] wordSelT;

	//////////////////////////////////////////////////////////////////////
	// bundles between blocks
	//////////////////////////////////////////////////////////////////////

	// processor request, held steady while stalled
	typedef struct packed {
		logic enable;
		logic write;
		addrT addr;
		wordT wdata;
	} cpuReqT;

	// memory request, read and write are exclusive
	typedef struct packed {
		logic read;
		logic write;
		addrT addr;
		wordT wdata;
	} memReqT;

	// one pulse per read, in issue order
	typedef struct packed {
		logic valid;
		wordT data;
	} memRspT;

	// single word write into the data store
	typedef struct packed {
		logic we;
		indexT index;
		wordSelT wordSel;
		wordT data;
	} arrayWrT;

	// miss controller states
	typedef enum logic [1:0] {IDLE, ISSUE, DRAIN} missStateT;

endpackage

//--- logic/cacheTop.sv
`timescale 1ns/1ns
`include "cache_defs.svh"

module cacheTop (
	input logic clk,
	input logic rst,
	input cachePkg::cpuReqT req,
	output cachePkg::wordT rdata,
	output logic hit,
	output logic stall
);

	//////////////////////////////////////////////////////////////////////
	// internal nets
	//////////////////////////////////////////////////////////////////////

	// memory side
	cachePkg::memReqT memReq;
	cachePkg::memRspT memRsp;

	// store writes from the controller
	cachePkg::arrayWrT arrayWr;
	logic tagWrite;

	// fill counter handshake
	logic issueStep;
	logic returnStep;
	logic clear;
	cachePkg::wordSelT issueWord;
	cachePkg::wordSelT returnWord;
	logic issueLast;
	logic returnLast;

	//////////////////////////////////////////////////////////////////////
	// controller and counters
	//////////////////////////////////////////////////////////////////////

	missFsm missCtrl (
		.clk(clk),
		.rst(rst),
		.req(req),
		.hit(hit),
		.memRsp(memRsp),
		.issueWord(issueWord),
		.returnWord(returnWord),
		.issueLast(issueLast),
		.returnLast(returnLast),
		.stall(stall),
		.memReq(memReq),
		.arrayWr(arrayWr),
		.tagWrite(tagWrite),
		.issueStep(issueStep),
		.returnStep(returnStep),
		.clear(clear)
	);

	fillCounter fillCnt (
		.clk(clk),
		.rst(rst),
		.clear(clear),
		.issueStep(issueStep),
		.returnStep(returnStep),
		.issueWord(issueWord),
		.returnWord(returnWord),
		.issueLast(issueLast),
		.returnLast(returnLast)
	);

	//////////////////////////////////////////////////////////////////////
	// stores
	//////////////////////////////////////////////////////////////////////

	// read port follows the processor address directly
	dataArray dataStore (
		.clk(clk),
		.arrayWr(arrayWr),
		.rdIndex(req.addr[`WORDSEL_W+1 +: `INDEX_W]),
		.rdWord(req.addr[1 +: `WORDSEL_W]),
		.rdata(rdata)
	);

	tagArray tagStore (
		.clk(clk),
		.rst(rst),
		.req(req),
		.tagWrite(tagWrite),
		.hit(hit)
	);

	mainMemory memory (
		.clk(clk),
		.rst(rst),
		.memReq(memReq),
		.memRsp(memRsp)
	);

endmodule

//--- logic/cache_defs.svh
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

//////////////////////////////////////////////////////////////////////
// address and data widths
//////////////////////////////////////////////////////////////////////

// byte address, bit 0 is ignored
`define ADDR_W 16
`define DATA_W 16

// address split: tag 15..11, index 10..4, word 3..1
`define TAG_W 5
`define INDEX_W 7
`define WORDSEL_W 3

//////////////////////////////////////////////////////////////////////
// cache geometry and memory timing
//////////////////////////////////////////////////////////////////////

`define NUM_LINES 128
`define WORDS_PER_LINE 8

// cycles from read accept to response valid
`define MEM_LATENCY 4

`endif

//--- logic/dataArray.sv
`timescale 1ns/1ns
`include "cache_defs.svh"

module dataArray (
	input logic clk,
	input cachePkg::arrayWrT arrayWr,
	input cachePkg::indexT rdIndex,
	input cachePkg::wordSelT rdWord,
	output cachePkg::wordT rdata
);

	//////////////////////////////////////////////////////////////////////
	// word storage
	//////////////////////////////////////////////////////////////////////

	// line by word, 1024 words in total
	cachePkg::wordT lines [`NUM_LINES][`WORDS_PER_LINE];

	// one word per edge, either a hit write or a fill word
	always_ff @(posedge clk) begin
		if (arrayWr.we) begin
			lines[arrayWr.index][arrayWr.wordSel] <= arrayWr.data;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// read port
	//////////////////////////////////////////////////////////////////////

	// combinational so hit data returns in the request cycle
	assign rdata = lines[rdIndex][rdWord];

endmodule

//--- logic/fillCounter.sv
`timescale 1ns/1ns
`include "cache_defs.svh"

module fillCounter (
	input logic clk,
	input logic rst,
	input logic clear,
	input logic issueStep,
	input logic returnStep,
	output cachePkg::wordSelT issueWord,
	output cachePkg::wordSelT returnWord,
	output logic issueLast,
	output logic returnLast
);

	//////////////////////////////////////////////////////////////////////
	// word counters
	//////////////////////////////////////////////////////////////////////

	// words requested so far in this fill
	always_ff @(posedge clk) begin
		if (rst || clear) begin
			issueWord <= '0;
		end else if (issueStep) begin
			issueWord <= issueWord + 1'b1;
		end
	end

	// words received so far, wraps back to zero after the line
	always_ff @(posedge clk) begin
		if (rst || clear) begin
			returnWord <= '0;
		end else if (returnStep) begin
			returnWord <= returnWord + 1'b1;
		end
	end

	// word seven closes each phase
	assign issueLast = issueWord == cachePkg::wordSelT'(`WORDS_PER_LINE - 1);
	assign returnLast = returnWord == cachePkg::wordSelT'(`WORDS_PER_LINE - 1);

	// a response always has an outstanding read behind it
	aReturnBehindIssue: assert property (@(posedge clk) disable iff (rst)
		returnStep |-> cachePkg::wordSelT'(issueWord - returnWord) != '0)
		else $error("return count passed issue count");

endmodule

//--- logic/mainMemory.sv
`timescale 1ns/1ns
`include "cache_defs.svh"

module mainMemory (
	input logic clk,
	input logic rst,
	input cachePkg::memReqT memReq,
	output cachePkg::memRspT memRsp
);

	// one word per even byte address
	cachePkg::wordT mem [2**(`ADDR_W-1)];

	// read pipeline, oldest at the top index
	logic [`MEM_LATENCY-1:0] validPipe;
	cachePkg::wordT dataPipe [`MEM_LATENCY];

	// word address drops byte bit 0
	logic [`ADDR_W-2:0] wordAddr;

	assign wordAddr = memReq.addr[`ADDR_W-1:1];

	//////////////////////////////////////////////////////////////////////
	// storage
	//////////////////////////////////////////////////////////////////////

	// contents start at zero
	initial begin
		for (int i = 0; i < 2**(`ADDR_W-1); i++) begin
			mem[i] = '0;
		end
	end

	// single cycle write
	always @(posedge clk) begin
		if (memReq.write) begin
			mem[wordAddr] <= memReq.wdata;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// read latency pipeline
	//////////////////////////////////////////////////////////////////////

	// valid stages carry one bit per accepted read
	always_ff @(posedge clk) begin
		if (rst) begin
			validPipe <= '0;
		end else begin
			validPipe <= {validPipe[`MEM_LATENCY-2:0], memReq.read};
		end
	end

	// data is sampled at accept and just follows the valid bits
	always_ff @(posedge clk) begin
		dataPipe[0] <= mem[wordAddr];
		for (int s = 1; s < `MEM_LATENCY; s++) begin
			dataPipe[s] <= dataPipe[s-1];
		end
	end

	assign memRsp.valid = validPipe[`MEM_LATENCY-1];
	assign memRsp.data = dataPipe[`MEM_LATENCY-1];

	// one operation per cycle
	aNoReadWrite: assert property (@(posedge clk) disable iff (rst)
		!(memReq.read && memReq.write))
		else $error("memory read and write in the same cycle");

endmodule

//--- logic/missFsm.sv
`timescale 1ns/1ns
`include "cache_defs.svh"

module missFsm (
	input logic clk,
	input logic rst,
	input cachePkg::cpuReqT req,
	input logic hit,
	input cachePkg::memRspT memRsp,
	input cachePkg::wordSelT issueWord,
	input cachePkg::wordSelT returnWord,
	input logic issueLast,
	input logic returnLast,
	output logic stall,
	output cachePkg::memReqT memReq,
	output cachePkg::arrayWrT arrayWr,
	output logic tagWrite,
	output logic issueStep,
	output logic returnStep,
	output logic clear
);

	cachePkg::missStateT state;
	cachePkg::missStateT nextState;

	// line base comes from the held request
	cachePkg::tagT reqTag;
	cachePkg::indexT reqIndex;

	assign reqTag = req.addr[`ADDR_W-1 -: `TAG_W];
	assign reqIndex = req.addr[`WORDSEL_W+1 +: `INDEX_W];

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= cachePkg::IDLE;
		end else begin
			state <= nextState;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// next state and outputs
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		nextState = state;
		stall = 1'b1;
		tagWrite = 1'b0;
		issueStep = 1'b0;
		returnStep = 1'b0;
		clear = 1'b0;
		// defaults point at the processor request
		memReq = '{read: 1'b0, write: 1'b0, addr: req.addr, wdata: req.wdata};
		arrayWr = '{we: 1'b0, index: reqIndex,
			wordSel: req.addr[1 +: `WORDSEL_W], data: req.wdata};
		case (state)
			cachePkg::IDLE: begin
				stall = req.enable & ~hit;
				// write-through: cache word and memory on the same edge
				memReq.write = req.enable & req.write & hit;
				arrayWr.we = req.enable & req.write & hit;
				if (req.enable && !hit) begin
					// counters start from word zero
					clear = 1'b1;
					nextState = cachePkg::ISSUE;
				end
			end
			cachePkg::ISSUE: begin
				// one read per cycle, word order
				memReq.read = 1'b1;
				memReq.addr = {reqTag, reqIndex, issueWord, 1'b0};
				issueStep = 1'b1;
				if (issueLast) begin
					nextState = cachePkg::DRAIN;
				end
			end
			cachePkg::DRAIN: begin
				// tag goes in with the final word
				if (memRsp.valid && returnLast) begin
					tagWrite = 1'b1;
					nextState = cachePkg::IDLE;
				end
			end
			default: begin
				nextState = cachePkg::IDLE;
			end
		endcase
		// early responses can land while reads are still going out
		if (state != cachePkg::IDLE && memRsp.valid) begin
			arrayWr.we = 1'b1;
			arrayWr.wordSel = returnWord;
			arrayWr.data = memRsp.data;
			returnStep = 1'b1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// checks
	//////////////////////////////////////////////////////////////////////

	// each fill is one burst of eight reads, none after it
	aReadBurst: assert property (@(posedge clk) disable iff (rst)
		state == cachePkg::IDLE ##1 state == cachePkg::ISSUE
		|-> memReq.read [*`WORDS_PER_LINE] ##1 !memReq.read)
		else $error("line fill read burst malformed");

	// tag update only in DRAIN, the line then hits
	aTagWrite: assert property (@(posedge clk) disable iff (rst)
		tagWrite |-> state == cachePkg::DRAIN ##1 hit)
		else $error("tag write outside DRAIN or no hit after fill");

endmodule

//--- logic/tagArray.sv
`timescale 1ns/1ns
`include "cache_defs.svh"

module tagArray (
	input logic clk,
	input logic rst,
	input cachePkg::cpuReqT req,
	input logic tagWrite,
	output logic hit
);

	// one valid bit and one tag per line
	logic [`NUM_LINES-1:0] validBits;
	cachePkg::tagT tags [`NUM_LINES];

	// request fields
	cachePkg::tagT reqTag;
	cachePkg::indexT reqIndex;

	assign reqTag = req.addr[`ADDR_W-1 -: `TAG_W];
	assign reqIndex = req.addr[`WORDSEL_W+1 +: `INDEX_W];

	//////////////////////////////////////////////////////////////////////
	// updates
	//////////////////////////////////////////////////////////////////////

	// every line starts invalid
	always_ff @(posedge clk) begin
		if (rst) begin
			validBits <= '0;
		end else if (tagWrite) begin
			validBits[reqIndex] <= 1'b1;
		end
	end

	// the request is held through the fill so its tag is still current
	always_ff @(posedge clk) begin
		if (tagWrite) begin
			tags[reqIndex] <= reqTag;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// lookup
	//////////////////////////////////////////////////////////////////////

	// idle requests never hit
	assign hit = req.enable & validBits[reqIndex] & (tags[reqIndex] == reqTag);

endmodule

//--- run.sh
#!/bin/sh
# builds the cache testbench with Verilator, runs it and scans the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=cacheSim

rm -rf obj_dir

verilator --binary --timing --assert -f src.f --top-module cacheTb -o "$BIN"
status=$?
if [ "$status" -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^Test completed successfully$" "$LOG"; then
	exit 0
fi
echo "pass message not found in $LOG"
exit 1

//--- src.f
+incdir+logic
logic/cachePkg.sv
logic/fillCounter.sv
logic/dataArray.sv
logic/tagArray.sv
logic/mainMemory.sv
logic/missFsm.sv
logic/cacheTop.sv
verif/cacheTb.sv

//--- verif/cacheTb.sv
`timescale 1ns/1ns
`include "cache_defs.svh"

module cacheTb;

	// one row of the stimulus table
	typedef struct packed {
		logic enable;
		logic write;
		cachePkg::addrT addr;
		// write data for writes, expected read data for reads
		cachePkg::wordT data;
		logic expHit;
	} stimT;

	logic clk;
	logic rst;
	cachePkg::cpuReqT req;
	cachePkg::wordT rdata;
	logic hit;
	logic stall;

	stimT stimTable[$];
	logic tableReady;
	int curEntry;
	int checkCount;
	int wordErrors;
	int bitErrors;

	// reference model of tags, valid bits and memory
	logic modelValid [`NUM_LINES];
	cachePkg::tagT modelTag [`NUM_LINES];
	cachePkg::wordT modelMem [2**(`ADDR_W-1)];

	cacheTop dut (
		.clk(clk),
		.rst(rst),
		.req(req),
		.rdata(rdata),
		.hit(hit),
		.stall(stall)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	//////////////////////////////////////////////////////////////////////
	// compare tasks
	//////////////////////////////////////////////////////////////////////

	task automatic checkWord(input string name, input cachePkg::addrT addr,
			input cachePkg::wordT got, input cachePkg::wordT exp);
		checkCount++;
		if (got !== exp) begin
			wordErrors++;
			$display("error: %s at addr %h got %h expected %h (entry %0d)",
				name, addr, got, exp, curEntry);
		end
	endtask

	task automatic checkBit(input string name, input logic got, input logic exp);
		checkCount++;
		if (got !== exp) begin
			bitErrors++;
			$display("error: %s got %h expected %h (entry %0d)", name, got, exp, curEntry);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// table construction from the model
	//////////////////////////////////////////////////////////////////////

	task automatic addEntry(input logic enable, input logic write, input cachePkg::tagT tag,
			input cachePkg::indexT index, input cachePkg::wordSelT word,
			input cachePkg::wordT wdata);
		stimT s;
		s.enable = enable;
		s.write = write;
		s.addr = {tag, index, word, 1'b0};
		s.data = wdata;
		// hit only when the line already holds this tag
		s.expHit = enable && modelValid[index] && (modelTag[index] == tag);
		if (enable) begin
			// a miss fills the whole line and then completes like a hit
			modelValid[index] = 1'b1;
			modelTag[index] = tag;
			if (write) begin
				modelMem[s.addr[`ADDR_W-1:1]] = wdata;
			end else begin
				s.data = modelMem[s.addr[`ADDR_W-1:1]];
			end
		end
		stimTable.push_back(s);
	endtask

	task automatic buildTable();
		int unsigned r;
		for (int i = 0; i < `NUM_LINES; i++) begin
			modelValid[i] = 1'b0;
			modelTag[i] = '0;
		end
		for (int i = 0; i < 2**(`ADDR_W-1); i++) begin
			modelMem[i] = '0;
		end
		// cold read, then write hit and read back
		addEntry(1'b1, 1'b0, 5'd3, 7'd5, 3'd2, '0);
		addEntry(1'b1, 1'b1, 5'd3, 7'd5, 3'd2, cachePkg::wordT'($urandom));
		addEntry(1'b1, 1'b0, 5'd3, 7'd5, 3'd2, '0);
		// rest of the filled line hits at once
		for (int w = 0; w < `WORDS_PER_LINE; w++) begin
			if (w != 2) begin
				addEntry(1'b1, 1'b0, 5'd3, 7'd5, cachePkg::wordSelT'(w), '0);
			end
		end
		// write-through survives eviction by a conflicting tag
		addEntry(1'b1, 1'b1, 5'd9, 7'd20, 3'd6, cachePkg::wordT'($urandom));
		addEntry(1'b1, 1'b0, 5'd22, 7'd20, 3'd6, '0);
		addEntry(1'b1, 1'b0, 5'd9, 7'd20, 3'd6, '0);
		// disabled requests leave stores and lines untouched
		addEntry(1'b0, 1'b1, 5'd3, 7'd5, 3'd4, cachePkg::wordT'($urandom));
		addEntry(1'b0, 1'b0, 5'd17, 7'd90, 3'd0, '0);
		addEntry(1'b1, 1'b0, 5'd3, 7'd5, 3'd4, '0);
		addEntry(1'b1, 1'b0, 5'd17, 7'd90, 3'd0, '0);
		// mixed traffic over two tags and four lines
		for (int i = 0; i < 40; i++) begin
			r = $urandom;
			addEntry(r[9:7] != 3'd0, r[6], cachePkg::tagT'(1 + r[0]),
				cachePkg::indexT'(40 + r[2:1]), cachePkg::wordSelT'(r[5:3]),
				cachePkg::wordT'($urandom));
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// apply one entry
	//////////////////////////////////////////////////////////////////////

	task automatic applyEntry(input stimT s);
		@(posedge clk);
		#1;
		req.enable = s.enable;
		req.write = s.write;
		req.addr = s.addr;
		req.wdata = s.data;
		#1;
		if (!s.enable) begin
			checkBit("stall", stall, 1'b0);
			checkBit("hit", hit, 1'b0);
		end else begin
			// a miss shows up as stall in the request cycle
			checkBit("stall", stall, !s.expHit);
			checkBit("hit", hit, s.expHit);
			while (stall) begin
				@(posedge clk);
				#2;
			end
			checkBit("hit", hit, 1'b1);
			if (!s.write) begin
				checkWord("rdata", s.addr, rdata, s.data);
			end
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		int unsigned seedInit;
		rst = 1'b1;
		req = '0;
		tableReady = 1'b0;
		curEntry = -1;
		checkCount = 0;
		wordErrors = 0;
		bitErrors = 0;
		seedInit = $urandom(32'hd8be_5a86);
		buildTable();
		tableReady = 1'b1;
		repeat (16) @(posedge clk);
		#1;
		rst = 1'b0;
		#1;
		// idle after reset
		checkBit("stall", stall, 1'b0);
		checkBit("hit", hit, 1'b0);
		foreach (stimTable[i]) begin
			curEntry = i;
			applyEntry(stimTable[i]);
		end
		@(posedge clk);
		#1;
		req = '0;
		repeat (2) @(posedge clk);
		$display("checks %0d, word errors %0d, bit errors %0d",
			checkCount, wordErrors, bitErrors);
		if (wordErrors == 0 && bitErrors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

	// watchdog sized from the table length
	initial begin
		wait (tableReady);
		repeat (stimTable.size() * 40 + 100) @(posedge clk);
		$display("timeout: the run did not finish in %0d cycles, stuck at entry %0d",
			stimTable.size() * 40 + 100, curEntry);
		$display("Test failed");
		$finish;
	end

endmodule
